//--- build.f
+incdir+common
common/uart_pkg.sv
uart/uart_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/uart_top.sv
tests/tb_uart.sv

//--- tests/tb_uart.sv
// UART peripheral testbench.
// Random register, transmit, receive and interrupt tests against a model.

`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart
    import uart_pkg::*;
;

    localparam int MAX_DIVISOR    = 15;
    localparam int TIMEOUT_CYCLES = 24 * `UART_FRAME_BITS * (MAX_DIVISOR + 1) + 2000;

    localparam logic [`UART_ADDR_WIDTH-1:0] CONTROL_BYTE = 4 * `UART_CONTROL_ADDR;
    localparam logic [`UART_ADDR_WIDTH-1:0] DIVISOR_BYTE = 4 * `UART_DIVISOR_ADDR;
    localparam logic [`UART_ADDR_WIDTH-1:0] DATA_BYTE    = 4 * `UART_DATA_ADDR;
    localparam logic [`UART_ADDR_WIDTH-1:0] ALIAS_BYTE   = 4 * 3;

    logic                        bus;
    logic                        rst_n;
    logic                        valid;
    logic                        write;
    logic [`UART_ADDR_WIDTH-1:0] address;
    word_t                       wdata;
    logic [3:0]                  wstrb;
    logic                        rx;
    word_t                       rdata;
    logic                        ready;
    logic                        irq;
    logic                        tx;

    logic [31:0] rng_state = 32'h1392c62f;
    int          cycle_count;

    uart_top u_uart_top (
        .bus     (bus),
        .rst_n   (rst_n),
        .valid   (valid),
        .write   (write),
        .address (address),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .rx      (rx),
        .rdata   (rdata),
        .ready   (ready),
        .irq     (irq),
        .tx      (tx)
    );

    initial begin
        bus = 1'b0;
        forever #5 bus = ~bus;
    end

    // Watchdog.
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge bus);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped by the watchdog.");
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Strobed bytes take the new value.
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic expected_irq(input logic [31:0] ctrl);
        return (ctrl[3] & ctrl[1]) | (ctrl[4] & ctrl[2]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic bus_write(input logic [`UART_ADDR_WIDTH-1:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
        valid   = 1'b1;
        write   = 1'b1;
        address = addr;
        wdata   = data;
        wstrb   = strb;
        @(posedge bus);
        #1;
        valid = 1'b0;
        write = 1'b0;
    endtask

    task automatic bus_read(input logic [`UART_ADDR_WIDTH-1:0] addr,
                            output logic [31:0] data);
        valid   = 1'b1;
        write   = 1'b0;
        address = addr;
        @(negedge bus);
        data = rdata;                                   // Before the closing edge.
        check_value("ready", ready, 1'b1);
        @(posedge bus);
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_for_flag(input int bit_pos);
        logic [31:0] rd;
        rd = '0;
        while (!rd[bit_pos]) begin
            bus_read(CONTROL_BYTE, rd);
        end
    endtask

    // Rebuild one frame from tx and time its leading low run.
    task automatic watch_tx_frame(input int divisor, input logic [7:0] value);
        int         bit_len;
        int         low_cycles;
        int         low_bits;
        logic       seen_high;
        logic [9:0] frame;
        bit_len    = divisor + 1;
        low_cycles = 0;
        seen_high  = 1'b0;
        frame      = '0;
        @(negedge bus);
        while (tx !== 1'b0) begin
            @(negedge bus);
        end
        for (int c = 0; c < `UART_FRAME_BITS * bit_len; c++) begin
            if (c > 0) begin
                @(negedge bus);
            end
            if (tx === 1'b1) begin
                seen_high = 1'b1;
            end else if (!seen_high) begin
                low_cycles++;
            end
            if (c % bit_len == bit_len / 2) begin
                frame[c / bit_len] = tx;                // Mid-bit sample.
            end
        end
        low_bits = 1;
        while (low_bits < 9 && !value[low_bits-1]) begin
            low_bits++;
        end
        check_value("tx start bit", frame[0], 1'b0);
        check_value("tx stop bit", frame[9], 1'b1);
        check_value("tx data", frame[8:1], value);
        check_value("tx low run cycles", low_cycles, low_bits * bit_len);
        @(posedge bus);
        #1;
    endtask

    task automatic send_rx_frame(input int divisor, input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int k = 0; k < `UART_FRAME_BITS; k++) begin
            rx = frame[k];
            repeat (divisor + 1) @(posedge bus);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] div_model;
        logic [31:0] ctrl_model;
        logic [3:0]  strb;
        logic [7:0]  value;
        int          divisor;

        rst_n   = 1'b0;
        valid   = 1'b0;
        write   = 1'b0;
        address = '0;
        wdata   = '0;
        wstrb   = '0;
        rx      = 1'b1;
        repeat (10) @(posedge bus);
        #1;
        rst_n = 1'b1;

        // Reset state.
        bus_read(CONTROL_BYTE, rd);
        check_value("control", rd, 32'h0);
        bus_read(DIVISOR_BYTE, rd);
        check_value("divisor", rd, 32'h0);
        bus_read(DATA_BYTE, rd);
        check_value("data", rd, 32'h0);
        @(negedge bus);
        check_value("tx", tx, 1'b1);
        check_value("irq", irq, 1'b0);
        @(posedge bus);
        #1;

        // Byte strobes on divisor and control.
        div_model = '0;
        for (int i = 0; i < 10; i++) begin
            r    = next_random();
            strb = next_random() & 32'hF;
            bus_write(DIVISOR_BYTE, r, strb);
            div_model = apply_strobes(div_model, r, strb);
            bus_read(DIVISOR_BYTE, rd);
            check_value("divisor", rd, div_model);
        end
        ctrl_model = '0;
        for (int i = 0; i < 6; i++) begin
            r    = next_random() & ~32'h1;                 // Never start a frame here.
            strb = next_random() & 32'hF;
            bus_write(CONTROL_BYTE, r, strb);
            ctrl_model = apply_strobes(ctrl_model, r, strb) & 32'h1F;
            bus_read(CONTROL_BYTE, rd);
            check_value("control", rd, ctrl_model);
            check_value("irq", irq, expected_irq(ctrl_model));
        end
        bus_write(CONTROL_BYTE, 32'h0, 4'hF);

        // Transmit.
        for (int i = 0; i < 12; i++) begin
            divisor = 2 + int'(next_random() % 14);
            r       = next_random();
            value   = r[7:0];
            bus_write(DIVISOR_BYTE, divisor, 4'hF);
            bus_write(DATA_BYTE, r, 4'hF);
            bus_write(CONTROL_BYTE, 32'h1, 4'hF);
            fork
                watch_tx_frame(divisor, value);
                begin
                    @(posedge bus);
                    #1;
                    bus_read(CONTROL_BYTE, rd);
                    check_value("tx_enable", rd[0], 1'b0);  // Self-cleared.
                end
            join
            wait_for_flag(1);
            check_value("tx", tx, 1'b1);
        end

        // Receive.
        for (int i = 0; i < 12; i++) begin
            divisor = 2 + int'(next_random() % 14);
            r       = next_random();
            value   = r[7:0];
            bus_write(DIVISOR_BYTE, divisor, 4'hF);
            bus_write(CONTROL_BYTE, 32'h0, 4'hF);
            send_rx_frame(divisor, value);
            wait_for_flag(2);
            bus_read(DATA_BYTE, rd);
            check_value("rx data", rd, {24'h0, value});
            bus_read(ALIAS_BYTE, rd);
            check_value("rx data alias", rd, {24'h0, value});
        end

        // Events and interrupt.
        for (int i = 0; i < 3; i++) begin
            r          = next_random();
            divisor    = 2 + int'(next_random() % 4);
            ctrl_model = {27'h0, r[1], r[0], 3'b000};       // Enables only.
            value      = r[15:8];
            bus_write(DIVISOR_BYTE, divisor, 4'hF);
            bus_write(DATA_BYTE, r >> 8, 4'hF);
            bus_write(CONTROL_BYTE, ctrl_model | 32'h1, 4'hF);
            watch_tx_frame(divisor, value);
            wait_for_flag(1);
            ctrl_model |= 32'h2;
            @(negedge bus);
            check_value("irq", irq, expected_irq(ctrl_model));
            @(posedge bus);
            #1;
            send_rx_frame(divisor, r[23:16]);
            wait_for_flag(2);
            ctrl_model |= 32'h4;
            bus_read(CONTROL_BYTE, rd);
            check_value("control", rd, ctrl_model);
            check_value("irq", irq, expected_irq(ctrl_model));
            ctrl_model &= 32'h18;                            // Clear both flags.
            bus_write(CONTROL_BYTE, ctrl_model, 4'hF);
            bus_read(CONTROL_BYTE, rd);
            check_value("control", rd, ctrl_model);
            check_value("irq", irq, 1'b0);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog/uart_top.sv
// UART peripheral top level.
// Register block with transmitter and receiver running side by side.

`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_top
    import uart_pkg::*;
(
    input  logic                        bus,
    input  logic                        rst_n,
    input  logic                        valid,
    input  logic                        write,
    input  logic [`UART_ADDR_WIDTH-1:0] address,
    input  word_t                       wdata,
    input  logic [`UART_WORD_WIDTH/8-1:0] wstrb,
    input  logic                        rx,
    output word_t                       rdata,
    output logic                        ready,
    output logic                        irq,
    output logic                        tx
);

    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_done;
    logic       rx_done;
    logic [7:0] rx_byte;
    word_t      divisor;

    uart_regs u_regs (
        .bus      (bus),
        .rst_n    (rst_n),
        .valid    (valid),
        .write    (write),
        .address  (address),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .tx_done  (tx_done),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte),
        .rdata    (rdata),
        .ready    (ready),
        .irq      (irq),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .divisor  (divisor)
    );

    uart_tx u_tx (
        .bus      (bus),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .divisor  (divisor),
        .tx       (tx),
        .tx_done  (tx_done)
    );

    uart_rx u_rx (
        .bus      (bus),
        .rst_n    (rst_n),
        .rx       (rx),
        .divisor  (divisor),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done)
    );

endmodule

//--- uart/uart_rx.sv
// UART receiver.
// Start bit detection, mid-period sampling and byte capture.

`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic       bus,
    input  logic       rst_n,
    input  logic       rx,
    input  word_t      divisor,
    output logic [7:0] rx_byte,
    output logic       rx_done
);

    localparam int INDEX_WIDTH = $clog2(`UART_FRAME_BITS);

    // Start bit plus 8 data bits are sampled.
    localparam logic [INDEX_WIDTH-1:0] INDEX_LAST = INDEX_WIDTH'(`UART_FRAME_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t                 state_q;
    word_t                  count_q;
    word_t                  half_divisor;
    logic [INDEX_WIDTH-1:0] index_q;
    logic [7:0]             shift_q;

    assign half_divisor = divisor >> 1;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state_q <= IDLE;
            rx_done <= 1'b0;
            rx_byte <= '0;
        end else begin
            rx_done <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (!rx) begin
                        state_q <= BUSY;
                        count_q <= divisor;
                        index_q <= INDEX_LAST;
                    end
                end
                BUSY: begin
                    if (index_q != '0) begin
                        if (count_q == half_divisor) begin
                            shift_q <= {rx, shift_q[7:1]};  // Start bit falls off the end.
                        end
                        if (count_q != '0) begin
                            count_q <= count_q - 1'b1;
                        end else begin
                            count_q <= divisor;
                            index_q <= index_q - 1'b1;
                        end
                    end else if (rx) begin
                        // Stop level seen.
                        state_q <= DONE;
                        rx_done <= 1'b1;
                        rx_byte <= shift_q;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    a_done_single_pulse: assert property (
        @(posedge bus) disable iff (!rst_n) rx_done |=> !rx_done
    );

endmodule

//--- uart/uart_tx.sv
// UART transmitter.
// Idle/busy/done FSM shifting out one 8N1 frame.

`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       bus,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  word_t      divisor,
    output logic       tx,
    output logic       tx_done
);

    localparam int INDEX_WIDTH = $clog2(`UART_FRAME_BITS);

    localparam logic [INDEX_WIDTH-1:0] INDEX_LAST = INDEX_WIDTH'(`UART_FRAME_BITS - 1);
    localparam logic [INDEX_WIDTH-1:0] INDEX_STOP = INDEX_WIDTH'(1);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t                 state_q;
    word_t                  count_q;
    logic [INDEX_WIDTH-1:0] index_q;
    logic [7:0]             shift_q;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state_q <= IDLE;
            tx      <= 1'b1;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (tx_start) begin
                        state_q <= BUSY;
                        count_q <= divisor;
                        index_q <= INDEX_LAST;
                        shift_q <= tx_byte;             // Private copy of the byte.
                        tx      <= 1'b0;                // Start bit.
                    end
                end
                BUSY: begin
                    if (count_q != '0) begin
                        count_q <= count_q - 1'b1;
                    end else if (index_q != '0) begin
                        count_q <= divisor;
                        tx      <= (index_q == INDEX_STOP) | shift_q[0];
                        shift_q <= {1'b0, shift_q[7:1]};   // LSB first.
                        index_q <= index_q - 1'b1;
                    end else begin
                        state_q <= DONE;
                        tx_done <= 1'b1;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    a_idle_line_high: assert property (
        @(posedge bus) disable iff (!rst_n) (state_q == IDLE) |-> tx
    );

endmodule

//--- uart/uart_regs.sv
// UART register block.
// Bus decode, control/divisor/data registers, event flags and interrupt.

`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_regs
    import uart_pkg::*;
(
    input  logic                        bus,
    input  logic                        rst_n,
    input  logic                        valid,
    input  logic                        write,
    input  logic [`UART_ADDR_WIDTH-1:0] address,
    input  word_t                       wdata,
    input  logic [`UART_WORD_WIDTH/8-1:0] wstrb,
    input  logic                        tx_done,
    input  logic                        rx_done,
    input  logic [7:0]                  rx_byte,
    output word_t                       rdata,
    output logic                        ready,
    output logic                        irq,
    output logic                        tx_start,
    output logic [7:0]                  tx_byte,
    output word_t                       divisor
);

    localparam int WORD_ADDR_WIDTH = `UART_ADDR_WIDTH - 2;
    localparam int STRB_WIDTH      = `UART_WORD_WIDTH / 8;

    localparam logic [WORD_ADDR_WIDTH-1:0] CONTROL_ADDR = WORD_ADDR_WIDTH'(`UART_CONTROL_ADDR);
    localparam logic [WORD_ADDR_WIDTH-1:0] DIVISOR_ADDR = WORD_ADDR_WIDTH'(`UART_DIVISOR_ADDR);
    localparam logic [WORD_ADDR_WIDTH-1:0] DATA_ADDR    = WORD_ADDR_WIDTH'(`UART_DATA_ADDR);

    logic [WORD_ADDR_WIDTH-1:0] word_addr;
    logic                       wr_en;
    uart_ctrl_u                 ctrl_q;
    uart_ctrl_u                 ctrl_wr;
    word_t                      divisor_q;
    logic [7:0]                 tx_byte_q;

    // Replace only the strobed bytes of the old value.
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input logic [STRB_WIDTH-1:0] strb);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign word_addr = address[`UART_ADDR_WIDTH-1:2];
    assign wr_en     = valid && write;

    always_comb begin
        ctrl_wr.word            = merge_bytes(ctrl_q.word, wdata, wstrb);
        ctrl_wr.fields.reserved = '0;                   // Reserved bits read as zero.
    end

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            ctrl_q.word <= '0;
        end else if (wr_en && word_addr == CONTROL_ADDR) begin
            ctrl_q <= ctrl_wr;                          // Write wins over done pulses.
        end else begin
            ctrl_q.fields.tx_enable <= 1'b0;
            if (tx_done) begin
                ctrl_q.fields.tx_event_flag <= 1'b1;
            end
            if (rx_done) begin
                ctrl_q.fields.rx_event_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            divisor_q <= '0;
        end else if (wr_en && word_addr == DIVISOR_ADDR) begin
            divisor_q <= merge_bytes(divisor_q, wdata, wstrb);
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            tx_byte_q <= '0;
        end else if (wr_en && word_addr == DATA_ADDR && wstrb[0]) begin
            tx_byte_q <= wdata[7:0];                    // Only the low byte is kept.
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read mux and outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (word_addr)
            CONTROL_ADDR: rdata = ctrl_q.word;
            DIVISOR_ADDR: rdata = divisor_q;
            default:      rdata = {{(`UART_WORD_WIDTH-8){1'b0}}, rx_byte};
        endcase
    end

    assign ready    = valid;
    assign tx_start = ctrl_q.fields.tx_enable;
    assign tx_byte  = tx_byte_q;
    assign divisor  = divisor_q;
    assign irq      = (ctrl_q.fields.tx_irq_enable && ctrl_q.fields.tx_event_flag) ||
                      (ctrl_q.fields.rx_irq_enable && ctrl_q.fields.rx_event_flag);

    // Engines come out of reset quiet.
    a_done_quiet_in_reset: assert property (
        @(posedge bus) !rst_n |=> !tx_done && !rx_done
    );

    // Starting a frame needs a usable bit period.
    a_divisor_valid_on_start: assert property (
        @(posedge bus) disable iff (!rst_n)
        (wr_en && word_addr == CONTROL_ADDR && wstrb[0] && wdata[0]) |-> divisor_q >= 2
    );

endmodule

//--- common/uart_pkg.sv
// UART shared types.
// Bus word and the control register, seen as a word and as fields.

`include "uart_settings.svh"

package uart_pkg;

    // One bus word.
    typedef logic [`UART_WORD_WIDTH-1:0] word_t;

    //////////////////////////////////////////////////////////////////////
    // Control register layout
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [`UART_WORD_WIDTH-6:0] reserved;       // Always zero.
        logic                        rx_irq_enable;  // Bit 4.
        logic                        tx_irq_enable;  // Bit 3.
        logic                        rx_event_flag;  // Bit 2.
        logic                        tx_event_flag;  // Bit 1.
        logic                        tx_enable;      // Bit 0, self-clearing.
    } uart_ctrl_t;

    // Merged and read back as a word, decoded by field for flags and irq.
    typedef union packed {
        word_t      word;
        uart_ctrl_t fields;
    } uart_ctrl_u;

endpackage

//--- common/uart_settings.svh
// UART sizing constants and register map.
// Word addresses are taken from byte address bits [3:2].

`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Bus data width.
`define UART_WORD_WIDTH 32

// Local byte address width.
`define UART_ADDR_WIDTH 4

// Start, 8 data and stop.
`define UART_FRAME_BITS 10

// Register word addresses. Word 3 aliases the data register on reads.
`define UART_CONTROL_ADDR 0
`define UART_DIVISOR_ADDR 1
`define UART_DATA_ADDR    2

`endif
